//--- logic/fetch_defines.svh
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// Address and instruction widths
`define XLEN 64
`define ILEN 32

// Reset pc, one word below the first fetch at 0x8000_0000
`define PC_RESET 64'h0000_0000_7FFF_FFFC

// Word model of the instruction memory
// Each word is the low half of its address XOR this salt
`define INST_SALT 32'h5A17_C3E9

// Stall pattern of the memory, must be nonzero
`define STALL_SEED 16'hACE1

`endif

//--- logic/fetch_pkg.sv
`include "fetch_defines.svh"

package fetch_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Basic fetch types
    ////////////////////////////////////////////////////////////////////////////

    // Byte address of an instruction
    typedef logic [`XLEN-1:0] addr_t;

    // One raw instruction word
    typedef logic [`ILEN-1:0] inst_t;

    ////////////////////////////////////////////////////////////////////////////
    // IF/ID payload
    ////////////////////////////////////////////////////////////////////////////

    // Fetched word with the address it came from
    // pc sits in the upper bits, 96 bits in total
    typedef struct packed {
        addr_t pc;
        inst_t inst;
    } fetch_pair_t;

endpackage

//--- logic/imem_if.sv
`timescale 1ns/1ps

// Fetch request and response channel to the instruction memory
// Request side is split: pc stage owns the strobe, next_pc the address
interface imem_if import fetch_pkg::*; ();

    // Request
    logic  req_valid;
    addr_t req_addr;
    logic  req_ready;

    // Response, one cycle after an accepted request
    logic  rsp_valid;
    inst_t rsp_inst;

    // pc stage, issues the strobe and pairs the answer
    modport fetch (
        output req_valid,
        input  req_addr,
        input  req_ready,
        input  rsp_valid,
        input  rsp_inst
    );

    // Next-pc unit, supplies the address and watches acceptance
    modport addr_gen (
        output req_addr,
        input  req_valid,
        input  req_ready
    );

    // Memory side
    modport mem (
        input  req_valid,
        input  req_addr,
        output req_ready,
        output rsp_valid,
        output rsp_inst
    );

endinterface

//--- logic/next_pc.sv
`timescale 1ns/1ps

module next_pc import fetch_pkg::*; (
    input  logic     I_sys_clk,
    input  logic     I_rst,
    input  logic     redirect_valid,
    input  addr_t    redirect_target,
    input  addr_t    pc_now,
    imem_if.addr_gen imem
);

    // Redirect held until a request carries it
    logic  redir_pending;
    addr_t redir_addr;

    // Plain sequential successor
    addr_t seq_addr;

    // Request taken by the memory this cycle
    logic  req_fire;

    assign seq_addr = pc_now + addr_t'(4);
    assign req_fire = imem.req_valid & imem.req_ready;

    ////////////////////////////////////////////////////////////////////////////
    // Pending redirect
    ////////////////////////////////////////////////////////////////////////////

    // New strobe wins over a clear in the same cycle
    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            redir_pending <= 1'b0;
        end else if (redirect_valid) begin
            redir_pending <= 1'b1;
        end else if (req_fire) begin
            redir_pending <= 1'b0;
        end
    end

    // Target only, latest strobe overwrites
    always_ff @(posedge I_sys_clk) begin
        if (redirect_valid) begin
            redir_addr <= redirect_target;
        end
    end

    // Address of the next request
    // Stays on the target across rejected requests
    assign imem.req_addr = redir_pending ? redir_addr : seq_addr;

endmodule

//--- logic/pc.sv
`timescale 1ns/1ps
`include "fetch_defines.svh"

module pc import fetch_pkg::*; (
    input  logic        I_sys_clk,
    input  logic        I_rst,
    imem_if.fetch       imem,
    input  logic        allowin,
    output addr_t       pc_now,
    output logic        fetch_valid,
    output fetch_pair_t fetch_pair
);

    // Request slot armed for this cycle
    logic        pc_valid;
    // Address of the last accepted request
    addr_t       pc_q;
    addr_t       pc_d;
    logic        rd_handshake;

    // Request went out last cycle, its answer is due now
    logic        input_valid;
    // Answer is here and matches a request
    logic        ifetch_valid;
    // Fetch may arm another request
    logic        fetch_allowin;

    // Stall cache
    logic        cache_valid;
    fetch_pair_t cache_pair;
    fetch_pair_t live_pair;

    ////////////////////////////////////////////////////////////////////////////
    // Request issue
    ////////////////////////////////////////////////////////////////////////////

    // No request unless IF/ID can take the answer
    assign imem.req_valid = pc_valid & allowin;
    assign rd_handshake   = imem.req_valid & imem.req_ready;

    // pc follows the address of each accepted request
    assign pc_d = rd_handshake ? imem.req_addr : pc_q;

    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            pc_q <= `PC_RESET;
        end else begin
            pc_q <= pc_d;
        end
    end

    // Rejected request leaves input_valid set with no answer
    // fetch_allowin then drops a cycle and the request goes out again
    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            input_valid <= 1'b0;
            pc_valid    <= 1'b0;
        end else begin
            input_valid <= imem.req_valid;
            pc_valid    <= fetch_allowin;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Response pairing
    ////////////////////////////////////////////////////////////////////////////

    assign ifetch_valid  = input_valid & imem.rsp_valid;
    assign fetch_allowin = ~input_valid | (imem.rsp_valid & allowin);

    // pc_q still holds the answered address in the response cycle
    assign live_pair = '{pc: pc_q, inst: imem.rsp_inst};

    // Payload of the cache, loaded on every live answer
    always_ff @(posedge I_sys_clk) begin
        if (ifetch_valid) begin
            cache_pair <= live_pair;
        end
    end

    // Set when IF/ID refuses a live answer
    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            cache_valid <= 1'b0;
        end else if (ifetch_valid & ~allowin) begin
            cache_valid <= 1'b1;
        end else if (cache_valid & allowin) begin
            cache_valid <= 1'b0;
        end
    end

    // Cached pair and live answer never meet
    assign fetch_valid = ifetch_valid | cache_valid;
    assign fetch_pair  = cache_valid ? cache_pair : live_pair;
    assign pc_now      = pc_q;

    // Held pair must sit still until IF/ID takes it
    a_cache_hold : assert property (@(posedge I_sys_clk) disable iff (I_rst)
        cache_valid && !allowin |=> cache_valid && $stable(fetch_pair))
        else $error("pc: cached pair changed before allowin");

endmodule

//--- logic/inst_rom.sv
`timescale 1ns/1ps
`include "fetch_defines.svh"

module inst_rom import fetch_pkg::*; (
    input  logic I_sys_clk,
    input  logic I_rst,
    imem_if.mem  imem
);

    // Stall generator state
    logic [15:0] lfsr;
    logic        lfsr_fb;

    // Request taken this cycle
    logic        req_fire;

    // Word for the requested address
    inst_t       rom_word;

    // Registered response
    logic        rsp_valid_q;
    inst_t       rsp_inst_q;

    ////////////////////////////////////////////////////////////////////////////
    // Stall generator
    ////////////////////////////////////////////////////////////////////////////

    // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
    assign lfsr_fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

    // Free running, steps every cycle whether or not a request comes
    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            lfsr <= `STALL_SEED;
        end else begin
            lfsr <= {lfsr[14:0], lfsr_fb};
        end
    end

    // Stall when both low bits are zero, about one cycle in four
    assign imem.req_ready = |lfsr[1:0];
    assign req_fire       = imem.req_valid & imem.req_ready;

    ////////////////////////////////////////////////////////////////////////////
    // Word model and response
    ////////////////////////////////////////////////////////////////////////////

    // No storage, the word follows from its address
    assign rom_word = imem.req_addr[`ILEN-1:0] ^ `INST_SALT;

    // One-cycle pulse per accepted request
    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= req_fire;
        end
    end

    // Word captured only on acceptance
    always_ff @(posedge I_sys_clk) begin
        if (req_fire) begin
            rsp_inst_q <= rom_word;
        end
    end

    assign imem.rsp_valid = rsp_valid_q;
    assign imem.rsp_inst  = rsp_inst_q;

    // Only word-aligned fetches are modeled
    a_req_align : assert property (@(posedge I_sys_clk) disable iff (I_rst)
        req_fire |-> imem.req_addr[1:0] == 2'b00)
        else $error("inst_rom: request address not word aligned");

endmodule

//--- logic/if_id_reg.sv
`timescale 1ns/1ps

module if_id_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     I_sys_clk,
    input  logic     I_rst,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     allowin,
    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_ready
);

    // Entry state
    logic     valid_q;
    payload_t data_q;

    ////////////////////////////////////////////////////////////////////////////
    // One-entry stage
    ////////////////////////////////////////////////////////////////////////////

    // Room when empty or being drained this cycle
    assign allowin = ~valid_q | out_ready;

    // Valid follows the input whenever the entry turns over
    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            valid_q <= 1'b0;
        end else if (allowin) begin
            valid_q <= in_valid;
        end
    end

    // Payload only on a real transfer
    always_ff @(posedge I_sys_clk) begin
        if (allowin && in_valid) begin
            data_q <= in_data;
        end
    end

    assign out_valid = valid_q;
    assign out_data  = data_q;

    // Fetch side keeps a refused item in place
    a_in_hold : assert property (@(posedge I_sys_clk) disable iff (I_rst)
        in_valid && !allowin |=> in_valid && $stable(in_data))
        else $error("if_id_reg: refused input changed before allowin");

endmodule

//--- logic/fetch_top.sv
`timescale 1ns/1ps
`include "fetch_defines.svh"

module fetch_top import fetch_pkg::*; (
    input  logic             I_sys_clk,
    input  logic             I_rst,
    input  logic             redirect_valid,
    input  logic [`XLEN-1:0] redirect_target,
    input  logic             id_ready,
    output logic             id_valid,
    output logic [`XLEN-1:0] id_pc,
    output logic [`ILEN-1:0] id_inst
);

    // Memory channel shared by pc, next_pc and the memory
    imem_if imem_bus ();

    // pc register fed back to next_pc
    addr_t       pc_now;

    // Fetch to IF/ID
    logic        fetch_valid;
    fetch_pair_t fetch_pair;
    logic        if_allowin;

    // IF/ID to decode
    fetch_pair_t id_pair;

    ////////////////////////////////////////////////////////////////////////////
    // Fetch front end
    ////////////////////////////////////////////////////////////////////////////

    next_pc u_next_pc (
        .I_sys_clk       (I_sys_clk),
        .I_rst           (I_rst),
        .redirect_valid  (redirect_valid),
        .redirect_target (redirect_target),
        .pc_now          (pc_now),
        .imem            (imem_bus.addr_gen)
    );

    pc u_pc (
        .I_sys_clk   (I_sys_clk),
        .I_rst       (I_rst),
        .imem        (imem_bus.fetch),
        .allowin     (if_allowin),
        .pc_now      (pc_now),
        .fetch_valid (fetch_valid),
        .fetch_pair  (fetch_pair)
    );

    inst_rom u_inst_rom (
        .I_sys_clk (I_sys_clk),
        .I_rst     (I_rst),
        .imem      (imem_bus.mem)
    );

    // IF/ID boundary carrying the pc/inst pair
    if_id_reg #(
        .payload_t (fetch_pair_t)
    ) u_if_id_reg (
        .I_sys_clk (I_sys_clk),
        .I_rst     (I_rst),
        .in_valid  (fetch_valid),
        .in_data   (fetch_pair),
        .allowin   (if_allowin),
        .out_valid (id_valid),
        .out_data  (id_pair),
        .out_ready (id_ready)
    );

    // Split the pair for decode
    assign id_pc   = id_pair.pc;
    assign id_inst = id_pair.inst;

endmodule

//--- sim/tb_fetch.sv
`timescale 1ns/1ps
`include "fetch_defines.svh"

module tb_fetch;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;
    localparam int MARGIN       = 200;
    localparam int NUM_PHASES   = 8;

    // DUT ports
    logic             I_sys_clk;
    logic             I_rst;
    logic             redirect_valid;
    logic [`XLEN-1:0] redirect_target;
    logic             id_ready;
    logic             id_valid;
    logic [`XLEN-1:0] id_pc;
    logic [`ILEN-1:0] id_inst;

    // One row of the stimulus table
    typedef struct {
        int               cycles;
        int               ready_pct;
        bit               redir_en;
        int               redir_cycle;
        logic [`XLEN-1:0] redir_target;
    } phase_t;

    phase_t           phases [NUM_PHASES];

    // Bookkeeping
    integer           seed;
    int               errors;
    int               transfers;
    int               total_cycles;
    int               cycle_count;
    int               phase_xfers;
    bit               strobe;

    // Reference model of the decode stream
    logic [`XLEN-1:0] exp_pc;
    bit               redir_pending;
    logic [`XLEN-1:0] redir_addr;
    bit               stale_ok;
    logic [`XLEN-1:0] stale_addr;
    int               slack;

    // Last cycle seen at the decode side
    bit               prev_stall;
    logic [`XLEN-1:0] prev_pc;
    logic [`ILEN-1:0] prev_inst;

    fetch_top dut (
        .I_sys_clk       (I_sys_clk),
        .I_rst           (I_rst),
        .redirect_valid  (redirect_valid),
        .redirect_target (redirect_target),
        .id_ready        (id_ready),
        .id_valid        (id_valid),
        .id_pc           (id_pc),
        .id_inst         (id_inst)
    );

    initial begin
        I_sys_clk = 1'b0;
        forever #(CLK_PERIOD / 2) I_sys_clk = ~I_sys_clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic compare(input string name, input logic [63:0] got,
                           input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic note_error(input string msg);
        errors++;
        $display("ERROR: %s at %0t", msg, $time);
    endtask

    // One item taken by decode, checked against the model
    task automatic track_transfer();
        logic [`XLEN-1:0] model_pc;
        logic [`ILEN-1:0] exp_inst;
        transfers++;
        if (!redir_pending) begin
            model_pc = exp_pc;
        end else if (id_pc === redir_addr) begin
            // Target reached, sequential from here
            model_pc      = redir_addr;
            redir_pending = 1'b0;
            stale_ok      = 1'b0;
        end else if (slack > 0 && id_pc === exp_pc) begin
            // Wrong-path item still in flight
            model_pc = exp_pc;
            slack--;
        end else if (slack > 0 && stale_ok && id_pc === stale_addr) begin
            // Earlier target fetched before the later strobe landed
            model_pc = stale_addr;
            slack--;
            stale_ok = 1'b0;
        end else begin
            model_pc      = redir_addr;
            redir_pending = 1'b0;
        end
        compare("id_pc", id_pc, model_pc);
        // Word rule of the memory model
        exp_inst = model_pc[`ILEN-1:0] ^ `INST_SALT;
        compare("id_inst", 64'(id_inst), 64'(exp_inst));
        exp_pc = model_pc + 64'd4;
    endtask

    // Strobe seen by the DUT at the coming edge
    task automatic register_redirect(input logic [`XLEN-1:0] target);
        if (redir_pending) begin
            stale_ok   = 1'b1;
            stale_addr = redir_addr;
        end
        redir_pending = 1'b1;
        redir_addr    = target;
        // At most two older items may still reach decode
        slack         = 2;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus table and main flow
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        I_rst           = 1'b1;
        redirect_valid  = 1'b0;
        redirect_target = '0;
        id_ready        = 1'b0;
        seed            = 67665;
        errors          = 0;
        transfers       = 0;
        cycle_count     = 0;
        exp_pc          = 64'h0000_0000_8000_0000;
        redir_pending   = 1'b0;
        redir_addr      = '0;
        stale_ok        = 1'b0;
        stale_addr      = '0;
        slack           = 0;
        prev_stall      = 1'b0;

        // Cycles, ready %, redirect enable, strobe cycle, target
        phases[0] = '{40,  100, 1'b0, 0,  64'h0};
        phases[1] = '{120, 60,  1'b0, 0,  64'h0};
        phases[2] = '{60,  100, 1'b1, 10, 64'h0000_0000_8000_1000};
        phases[3] = '{60,  50,  1'b1, 20, 64'h0000_0000_8000_2000};
        // Back to back strobes across phases 4 and 5
        phases[4] = '{20,  80,  1'b1, 19, 64'h0000_0000_8000_3000};
        phases[5] = '{60,  80,  1'b1, 0,  64'h0000_0000_8000_4000};
        phases[6] = '{80,  30,  1'b0, 0,  64'h0};
        phases[7] = '{40,  100, 1'b0, 0,  64'h0};

        total_cycles = 0;
        for (int p = 0; p < NUM_PHASES; p++) begin
            total_cycles += phases[p].cycles;
        end

        // Reset, decode side must stay quiet
        repeat (RESET_CYCLES) begin
            @(negedge I_sys_clk);
            compare("id_valid", 64'(id_valid), 64'd0);
        end
        I_rst = 1'b0;

        for (int p = 0; p < NUM_PHASES; p++) begin
            phase_xfers = 0;
            for (int c = 0; c < phases[p].cycles; c++) begin
                @(negedge I_sys_clk);
                strobe          = phases[p].redir_en && (c == phases[p].redir_cycle);
                redirect_valid  = strobe;
                redirect_target = strobe ? phases[p].redir_target : '0;
                id_ready        = ({$random(seed)} % 100) < phases[p].ready_pct;

                // No item can reach decode this early
                if (cycle_count < 2) begin
                    compare("id_valid", 64'(id_valid), 64'd0);
                end
                // Held item under back-pressure
                if (prev_stall) begin
                    compare("id_valid", 64'(id_valid), 64'd1);
                    compare("id_pc", id_pc, prev_pc);
                    compare("id_inst", 64'(id_inst), 64'(prev_inst));
                end
                if (id_valid && id_ready) begin
                    track_transfer();
                    phase_xfers++;
                end
                if (strobe) begin
                    register_redirect(phases[p].redir_target);
                end
                prev_stall  = id_valid && !id_ready;
                prev_pc     = id_pc;
                prev_inst   = id_inst;
                cycle_count++;
            end
            if (phase_xfers == 0) begin
                note_error($sformatf("no item reached decode in phase %0d", p));
            end
        end

        @(negedge I_sys_clk);
        redirect_valid = 1'b0;
        if (redir_pending) begin
            note_error("redirect target never reached decode");
        end

        $display("tb_fetch: %0d transfers, %0d errors", transfers, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Watchdog, sized from the table
    initial begin
        wait (total_cycles > 0);
        #((RESET_CYCLES + total_cycles + MARGIN) * CLK_PERIOD);
        $display("ERROR: watchdog expired, the run hung");
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- list.f
+incdir+logic
logic/fetch_pkg.sv
logic/imem_if.sv
logic/next_pc.sv
logic/pc.sv
logic/inst_rom.sv
logic/if_id_reg.sv
logic/fetch_top.sv
sim/tb_fetch.sv

//--- run.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_fetch -Mdir obj_dir -f list.f \
    || { echo "Verilator build failed"; exit 1; }

sim_out="$(./obj_dir/Vtb_fetch)"
echo "$sim_out"

echo "$sim_out" | grep -qx "PASS: all tests" && exit 0 || exit 1
